// ==== design/drive_engine.sv ====
/*
 * Drive family engine
 * forms the SD request for one family and fills its own sector buffer
 */

`timescale 1ns/1ps

module drive_engine #(
   parameter int LBA_SHIFT = 0,
   parameter int BLK_CNT   = 1,
   parameter int AW        = 10
) (
   input  logic                          clk_sys,
   input  logic                          reset_i,

   // drive side
   input  logic                          req_i,
   input  logic [31:0]                   lba_i,
   input  logic [AW-1:0]                 rd_addr_i,
   output logic [7:0]                    rd_data_o,
   output logic                          done_o,
   output logic                          busy_o,

   // SD host side
   output drive_pkg::sd_req_t            sd_req_o,
   input  logic                          sd_ack_i,
   input  logic [drive_pkg::BUF_AW-1:0]  sd_buff_addr_i,
   input  logic [7:0]                    sd_buff_dout_i,
   input  logic                          sd_buff_wr_i
);

   logic        accept;
   logic        rd;
   logic        xfer;
   logic        last;
   logic        byte_wr;
   logic [31:0] lba_q;

   // a request counts only when the FSM is free
   assign accept = req_i && !busy_o;

   // only bytes seen in the transfer state are stored
   assign byte_wr = sd_buff_wr_i && xfer;

   always_ff @(posedge clk_sys) begin
      if (accept) begin
         lba_q <= lba_i << LBA_SHIFT;
      end
   end

   assign sd_req_o.lba     = lba_q;
   assign sd_req_o.blk_cnt = 6'(BLK_CNT);
   assign sd_req_o.rd      = rd;

   sector_fsm fsm0 (
      .clk_sys  (clk_sys),
      .reset_i  (reset_i),
      .req_i    (accept),
      .sd_ack_i (sd_ack_i),
      .last_i   (last),
      .rd_o     (rd),
      .xfer_o   (xfer),
      .done_o   (done_o),
      .busy_o   (busy_o)
   );

   xfer_counter #(.BLK_CNT(BLK_CNT)) cnt0 (
      .clk_sys  (clk_sys),
      .reset_i  (reset_i),
      .clear_i  (accept),
      .count_i  (byte_wr),
      .last_o   (last)
   );

   sector_buffer #(.AW(AW)) buf0 (
      .clk_sys  (clk_sys),
      .we_i     (byte_wr),
      .waddr_i  (sd_buff_addr_i[AW-1:0]),
      .wdata_i  (sd_buff_dout_i),
      .raddr_i  (rd_addr_i),
      .rdata_o  (rd_data_o)
   );

endmodule

// ==== design/drive_pkg.sv ====
/*
 * Drive front end shared definitions
 * image family encoding, SD request bundle and buffer sizing
 */

package drive_pkg;

   // -------------------------------------------------------------------------
   // image family
   // -------------------------------------------------------------------------

   // latched from the image type at mount time
   typedef enum logic {
      IMG_GCR = 1'b0,
      IMG_MFM = 1'b1
   } img_type_t;

   // -------------------------------------------------------------------------
   // SD host request
   // -------------------------------------------------------------------------

   // one read request towards the SD host
   // lba and blk_cnt are held stable while rd is high
   typedef struct packed {
      logic [31:0] lba;
      logic [5:0]  blk_cnt;
      logic        rd;
   } sd_req_t;

   // -------------------------------------------------------------------------
   // sizing
   // -------------------------------------------------------------------------

   // bytes in one SD block
   localparam int BLK_BYTES = 512;

   // address width of the largest sector buffer, two blocks
   localparam int BUF_AW = 10;

endpackage

// ==== design/drive_subsys.sv ====
/*
 * Disk image front end
 * GCR and MFM drive engines behind a family selector, one SD host port
 */

`timescale 1ns/1ps

module drive_subsys #(
   parameter int GCR_BLK_CNT   = 2,
   parameter int MFM_LBA_SHIFT = 1,
   parameter int BUF_AW        = drive_pkg::BUF_AW
) (
   input  logic                 clk_sys,
   input  logic                 reset_i,

   // mount side
   input  logic                 img_mounted_i,
   input  logic [31:0]          img_size_i,
   input  drive_pkg::img_type_t img_type_i,

   // drive side
   input  logic                 req_i,
   input  logic [31:0]          lba_i,
   input  logic [BUF_AW-1:0]    rd_addr_i,
   output logic [7:0]           rd_data_o,
   output logic                 done_o,
   output logic                 busy_o,
   output logic                 led_o,

   // SD host side
   output drive_pkg::sd_req_t   sd_req_o,
   input  logic                 sd_ack_i,
   input  logic [BUF_AW-1:0]    sd_buff_addr_i,
   input  logic [7:0]           sd_buff_dout_i,
   input  logic                 sd_buff_wr_i
);

   import drive_pkg::*;

   logic       gcr_reset;
   logic       mfm_reset;
   logic       gcr_req;
   logic       mfm_req;
   sd_req_t    gcr_sd_req;
   sd_req_t    mfm_sd_req;
   logic [7:0] gcr_rd_data;
   logic [7:0] mfm_rd_data;
   logic       gcr_done;
   logic       mfm_done;
   logic       gcr_busy;
   logic       mfm_busy;

   // -------------------------------------------------------------------------
   // GCR family, plain lba, two blocks per fetch
   // -------------------------------------------------------------------------

   drive_engine #(
      .LBA_SHIFT (0),
      .BLK_CNT   (GCR_BLK_CNT),
      .AW        (BUF_AW)
   ) gcr_eng0 (
      .clk_sys        (clk_sys),
      .reset_i        (gcr_reset),
      .req_i          (gcr_req),
      .lba_i          (lba_i),
      .rd_addr_i      (rd_addr_i),
      .rd_data_o      (gcr_rd_data),
      .done_o         (gcr_done),
      .busy_o         (gcr_busy),
      .sd_req_o       (gcr_sd_req),
      .sd_ack_i       (sd_ack_i),
      .sd_buff_addr_i (sd_buff_addr_i),
      .sd_buff_dout_i (sd_buff_dout_i),
      .sd_buff_wr_i   (sd_buff_wr_i)
   );

   // -------------------------------------------------------------------------
   // MFM family, doubled lba, one block per fetch
   // -------------------------------------------------------------------------

   drive_engine #(
      .LBA_SHIFT (MFM_LBA_SHIFT),
      .BLK_CNT   (1),
      .AW        (BUF_AW - 1)
   ) mfm_eng0 (
      .clk_sys        (clk_sys),
      .reset_i        (mfm_reset),
      .req_i          (mfm_req),
      .lba_i          (lba_i),
      .rd_addr_i      (rd_addr_i[BUF_AW-2:0]),
      .rd_data_o      (mfm_rd_data),
      .done_o         (mfm_done),
      .busy_o         (mfm_busy),
      .sd_req_o       (mfm_sd_req),
      .sd_ack_i       (sd_ack_i),
      .sd_buff_addr_i (sd_buff_addr_i),
      .sd_buff_dout_i (sd_buff_dout_i),
      .sd_buff_wr_i   (sd_buff_wr_i)
   );

   family_select sel0 (
      .clk_sys       (clk_sys),
      .reset_i       (reset_i),
      .img_mounted_i (img_mounted_i),
      .img_size_i    (img_size_i),
      .img_type_i    (img_type_i),
      .req_i         (req_i),
      .gcr_sd_req_i  (gcr_sd_req),
      .mfm_sd_req_i  (mfm_sd_req),
      .gcr_rd_data_i (gcr_rd_data),
      .mfm_rd_data_i (mfm_rd_data),
      .gcr_done_i    (gcr_done),
      .mfm_done_i    (mfm_done),
      .gcr_busy_i    (gcr_busy),
      .mfm_busy_i    (mfm_busy),
      .gcr_reset_o   (gcr_reset),
      .mfm_reset_o   (mfm_reset),
      .gcr_req_o     (gcr_req),
      .mfm_req_o     (mfm_req),
      .sd_req_o      (sd_req_o),
      .rd_data_o     (rd_data_o),
      .done_o        (done_o),
      .busy_o        (busy_o),
      .led_o         (led_o)
   );

endmodule

// ==== design/family_select.sv ====
/*
 * Drive family selector
 * latches the image type on mount, holds the idle engine in reset
 * and passes through the results of the active one
 */

`timescale 1ns/1ps

module family_select (
   input  logic                 clk_sys,
   input  logic                 reset_i,

   // mount side
   input  logic                 img_mounted_i,
   input  logic [31:0]          img_size_i,
   input  drive_pkg::img_type_t img_type_i,

   // drive request
   input  logic                 req_i,

   // engine results
   input  drive_pkg::sd_req_t   gcr_sd_req_i,
   input  drive_pkg::sd_req_t   mfm_sd_req_i,
   input  logic [7:0]           gcr_rd_data_i,
   input  logic [7:0]           mfm_rd_data_i,
   input  logic                 gcr_done_i,
   input  logic                 mfm_done_i,
   input  logic                 gcr_busy_i,
   input  logic                 mfm_busy_i,

   // engine control
   output logic                 gcr_reset_o,
   output logic                 mfm_reset_o,
   output logic                 gcr_req_o,
   output logic                 mfm_req_o,

   // selected results
   output drive_pkg::sd_req_t   sd_req_o,
   output logic [7:0]           rd_data_o,
   output logic                 done_o,
   output logic                 busy_o,
   output logic                 led_o
);

   import drive_pkg::*;

   img_type_t family_q;
   logic      is_mfm;

   // -------------------------------------------------------------------------
   // family register
   // -------------------------------------------------------------------------

   // an empty image leaves the current family in place
   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         family_q <= IMG_GCR;
      end else if (img_mounted_i && (img_size_i != '0)) begin
         family_q <= img_type_i;
      end
   end

   assign is_mfm = (family_q == IMG_MFM);

   // idle engine stays in reset
   assign gcr_reset_o = reset_i || is_mfm;
   assign mfm_reset_o = reset_i || !is_mfm;

   assign gcr_req_o = req_i && !is_mfm;
   assign mfm_req_o = req_i && is_mfm;

   // -------------------------------------------------------------------------
   // output mux
   // -------------------------------------------------------------------------

   assign sd_req_o  = is_mfm ? mfm_sd_req_i  : gcr_sd_req_i;
   assign rd_data_o = is_mfm ? mfm_rd_data_i : gcr_rd_data_i;
   assign done_o    = is_mfm ? mfm_done_i    : gcr_done_i;
   assign busy_o    = is_mfm ? mfm_busy_i    : gcr_busy_i;

   // activity from either family lights the LED
   assign led_o = gcr_busy_i | mfm_busy_i;

endmodule

// ==== design/sector_buffer.sv ====
/*
 * Sector buffer
 * byte memory, written by the SD host, read by the drive side
 */

`timescale 1ns/1ps

module sector_buffer #(
   parameter int AW = 10
) (
   input  logic          clk_sys,

   input  logic          we_i,
   input  logic [AW-1:0] waddr_i,
   input  logic [7:0]    wdata_i,

   input  logic [AW-1:0] raddr_i,
   output logic [7:0]    rdata_o
);

   logic [7:0] mem [2**AW];

   always_ff @(posedge clk_sys) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // registered read, data one cycle after the address
   always_ff @(posedge clk_sys) begin
      rdata_o <= mem[raddr_i];
   end

endmodule

// ==== design/sector_fsm.sv ====
/*
 * Sector fetch FSM
 * raises an SD read on request, waits for the ack and the last byte,
 * then pulses done for one cycle
 */

`timescale 1ns/1ps

module sector_fsm (
   input  logic clk_sys,
   input  logic reset_i,

   input  logic req_i,
   input  logic sd_ack_i,
   input  logic last_i,

   output logic rd_o,
   output logic xfer_o,
   output logic done_o,
   output logic busy_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_REQ,
      S_XFER,
      S_DONE
   } state_t;

   state_t state_q;
   state_t state_d;

   // -------------------------------------------------------------------------
   // next state
   // -------------------------------------------------------------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (req_i) begin
               state_d = S_REQ;
            end
         end
         // rd stays up until the host acknowledges
         S_REQ: begin
            if (sd_ack_i) begin
               state_d = S_XFER;
            end
         end
         // bytes arrive here, last_i marks the final one
         S_XFER: begin
            if (last_i) begin
               state_d = S_DONE;
            end
         end
         // not busy any more, so a new request may start right away
         S_DONE: begin
            if (req_i) begin
               state_d = S_REQ;
            end else begin
               state_d = S_IDLE;
            end
         end
         default: begin
            state_d = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // -------------------------------------------------------------------------
   // outputs, decoded from the state register
   // -------------------------------------------------------------------------

   assign rd_o   = (state_q == S_REQ);
   assign xfer_o = (state_q == S_XFER);
   assign done_o = (state_q == S_DONE);
   // busy drops together with the done pulse
   assign busy_o = (state_q == S_REQ) || (state_q == S_XFER);

endmodule

// ==== design/xfer_counter.sv ====
/*
 * Transfer byte counter
 * counts stored bytes of one fetch and flags the final one
 */

`timescale 1ns/1ps

module xfer_counter #(
   parameter int BLK_CNT = 1
) (
   input  logic clk_sys,
   input  logic reset_i,

   input  logic clear_i,
   input  logic count_i,

   output logic last_o
);

   import drive_pkg::*;

   localparam int TOTAL = BLK_CNT * BLK_BYTES;
   localparam int CW    = $clog2(TOTAL) + 1;

   logic [CW-1:0] cnt_q;

   // restarts on every accepted request
   always_ff @(posedge clk_sys) begin
      if (reset_i || clear_i) begin
         cnt_q <= '0;
      end else if (count_i) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // combinational so it lines up with the completing strobe
   assign last_o = count_i && (cnt_q == CW'(TOTAL - 1));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the drive front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_drive_subsys -f verilog.f \
   -Mdir obj_dir -o tb_drive_subsys
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/tb_drive_subsys)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== test/tb_drive_subsys.sv ====
/*
 * Drive front end testbench
 * mounts GCR and MFM images, fetches sectors through the SD model
 * and checks request fields, strobes and buffer contents
 */

`timescale 1ns/1ps

module tb_drive_subsys;

   import drive_pkg::*;

   localparam int CLK_HALF    = 20;
   localparam int DONE_LIMIT  = 3000;
   localparam int WATCHDOG_NS = 8 * 1100 * 40;

   logic        clk_sys;
   logic        reset_i;
   logic        img_mounted_i;
   logic [31:0] img_size_i;
   img_type_t   img_type_i;
   logic        req_i;
   logic [31:0] lba_i;
   logic [9:0]  rd_addr_i;
   logic [7:0]  rd_data_o;
   logic        done_o;
   logic        busy_o;
   logic        led_o;
   sd_req_t     sd_req_o;
   logic        sd_ack;
   logic [9:0]  sd_buff_addr;
   logic [7:0]  sd_buff_dout;
   logic        sd_buff_wr;
   logic [31:0] sd_lba;

   // expected strobes, stepped at each negedge
   logic        exp_rd;
   logic        exp_xfer;
   logic        exp_busy;
   logic        exp_done;
   logic        exp_mfm;
   logic        track_on;
   int          wr_seen;
   int          total;

   int          err_cnt;
   int          fetch_cnt;
   int          byte_cnt;
   int          done_cnt;
   int          done_mark;
   logic [31:0] lfsr_state;
   logic [31:0] lba_a;
   logic [31:0] lba_b;

   // expected SD byte at one buffer address
   function automatic logic [7:0] sector_byte(input logic [31:0] lba, input logic [9:0] addr);
      return (lba[7:0] ^ addr[7:0]) + {6'd0, addr[9:8]};
   endfunction

   // galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      int          i;
      val = '0;
      for (i = 0; i < n; i++) begin
         val = {val[30:0], lfsr_state[0]};
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
      end
      return val;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      err_cnt++;
   endtask

   drive_subsys dut0 (
      .clk_sys        (clk_sys),
      .reset_i        (reset_i),
      .img_mounted_i  (img_mounted_i),
      .img_size_i     (img_size_i),
      .img_type_i     (img_type_i),
      .req_i          (req_i),
      .lba_i          (lba_i),
      .rd_addr_i      (rd_addr_i),
      .rd_data_o      (rd_data_o),
      .done_o         (done_o),
      .busy_o         (busy_o),
      .led_o          (led_o),
      .sd_req_o       (sd_req_o),
      .sd_ack_i       (sd_ack),
      .sd_buff_addr_i (sd_buff_addr),
      .sd_buff_dout_i (sd_buff_dout),
      .sd_buff_wr_i   (sd_buff_wr)
   );

   tb_sd_model sd0 (
      .clk_sys        (clk_sys),
      .sd_req_i       (sd_req_o),
      .sd_ack_o       (sd_ack),
      .sd_buff_addr_o (sd_buff_addr),
      .sd_buff_wr_o   (sd_buff_wr),
      .lba_o          (sd_lba)
   );

   // the SD model sends the reference byte for its own lba
   assign sd_buff_dout = sector_byte(sd_lba, sd_buff_addr);

   initial begin
      clk_sys = 1'b0;
      forever #CLK_HALF clk_sys = ~clk_sys;
   end

   // ------------------------------------------------------------------------
   // cycle tracker for rd, busy, led and done
   // ------------------------------------------------------------------------

   initial begin
      track_on = 1'b0;
      done_cnt = 0;
   end

   always @(negedge clk_sys) begin
      if (track_on) begin
         if (sd_req_o.rd !== exp_rd) report_mismatch("sd_req_o.rd", 32'(exp_rd), 32'(sd_req_o.rd));
         if (busy_o !== exp_busy) report_mismatch("busy_o", 32'(exp_busy), 32'(busy_o));
         if (led_o !== exp_busy) report_mismatch("led_o", 32'(exp_busy), 32'(led_o));
         if (done_o !== exp_done) report_mismatch("done_o", 32'(exp_done), 32'(done_o));
         if (done_o === 1'b1) done_cnt++;
      end
      // inputs seen now are sampled by the coming edge
      if (reset_i) begin
         exp_rd   = 1'b0;
         exp_xfer = 1'b0;
         exp_busy = 1'b0;
         exp_done = 1'b0;
         exp_mfm  = 1'b0;
         wr_seen  = 0;
         track_on = 1'b1;
      end else begin
         exp_done = 1'b0;
         total    = exp_mfm ? BLK_BYTES : 2 * BLK_BYTES;
         if (exp_xfer && sd_buff_wr) begin
            wr_seen++;
            if (wr_seen == total) begin
               exp_xfer = 1'b0;
               exp_busy = 1'b0;
               exp_done = 1'b1;
            end
         end else if (exp_rd && sd_ack) begin
            exp_rd   = 1'b0;
            exp_xfer = 1'b1;
         end else if (!exp_busy && req_i) begin
            exp_rd   = 1'b1;
            exp_busy = 1'b1;
            wr_seen  = 0;
         end
         if (img_mounted_i && img_size_i != 32'd0) exp_mfm = (img_type_i == IMG_MFM);
      end
   end

   // ------------------------------------------------------------------------
   // stimulus tasks
   // ------------------------------------------------------------------------

   task automatic mount_image(input img_type_t kind, input logic [31:0] size);
      @(posedge clk_sys);
      #2;
      img_mounted_i = 1'b1;
      img_type_i    = kind;
      img_size_i    = size;
      @(posedge clk_sys);
      #2;
      img_mounted_i = 1'b0;
      img_size_i    = '0;
   endtask

   task automatic pulse_req(input logic [31:0] lba);
      @(posedge clk_sys);
      #2;
      req_i = 1'b1;
      lba_i = lba;
      @(posedge clk_sys);
      #2;
      req_i = 1'b0;
   endtask

   // request, then rd and the request fields one cycle later
   task automatic start_fetch(input logic [31:0] lba, input logic [31:0] exp_lba,
                              input int exp_blk);
      done_mark = done_cnt;
      fetch_cnt++;
      pulse_req(lba);
      if (sd_req_o.rd !== 1'b1) report_mismatch("sd_req_o.rd", 32'd1, 32'(sd_req_o.rd));
      if (sd_req_o.lba !== exp_lba) report_mismatch("sd_req_o.lba", exp_lba, sd_req_o.lba);
      if (sd_req_o.blk_cnt !== 6'(exp_blk)) begin
         report_mismatch("sd_req_o.blk_cnt", 32'(exp_blk), 32'(sd_req_o.blk_cnt));
      end
   endtask

   task automatic wait_done(input int settle);
      int cycles;
      cycles = 0;
      while (done_cnt == done_mark && cycles < DONE_LIMIT) begin
         @(posedge clk_sys);
         #2;
         cycles++;
      end
      if (done_cnt == done_mark) begin
         $display("done_o did not pulse within %0d cycles of the request", DONE_LIMIT);
         err_cnt++;
      end
      repeat (settle) @(posedge clk_sys);
      #2;
      if (done_cnt != done_mark + 1) begin
         report_mismatch("done_o pulses", 32'd1, 32'(done_cnt - done_mark));
      end
   endtask

   // registered read, each byte is checked one cycle after its address
   task automatic check_buffer(input logic [31:0] lba, input int nbytes);
      int         a;
      logic [7:0] exp;
      rd_addr_i = '0;
      for (a = 0; a < nbytes; a++) begin
         @(posedge clk_sys);
         #2;
         exp = sector_byte(lba, a[9:0]);
         if (rd_data_o !== exp) begin
            $display("[FAIL] rd_data_o at addr %h expected %h got %h", a[9:0], exp, rd_data_o);
            err_cnt++;
         end
         byte_cnt++;
         rd_addr_i = 10'(a + 1);
      end
   endtask

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------

   initial begin
      reset_i       = 1'b1;
      img_mounted_i = 1'b0;
      img_size_i    = '0;
      img_type_i    = IMG_GCR;
      req_i         = 1'b0;
      lba_i         = '0;
      rd_addr_i     = '0;
      err_cnt       = 0;
      fetch_cnt     = 0;
      byte_cnt      = 0;
      done_mark     = 0;
      lfsr_state    = 32'd81;
      repeat (2) @(posedge clk_sys);
      #2;
      reset_i = 1'b0;
      @(posedge clk_sys);
      #2;
      if (sd_req_o.rd !== 1'b0) report_mismatch("sd_req_o.rd", 32'd0, 32'(sd_req_o.rd));
      if (done_o !== 1'b0) report_mismatch("done_o", 32'd0, 32'(done_o));
      if (busy_o !== 1'b0) report_mismatch("busy_o", 32'd0, 32'(busy_o));
      if (led_o !== 1'b0) report_mismatch("led_o", 32'd0, 32'(led_o));

      // GCR image, plain lba and two blocks
      mount_image(IMG_GCR, 32'h0002_AB00);
      lba_a = take_bits(28);
      start_fetch(lba_a, lba_a, 2);
      wait_done(4);
      check_buffer(lba_a, 1024);

      // MFM image, doubled lba and one block
      mount_image(IMG_MFM, 32'h000B_4000);
      lba_a = take_bits(28);
      start_fetch(lba_a, lba_a << 1, 1);
      wait_done(4);
      check_buffer(lba_a << 1, 512);

      // empty image keeps the MFM family
      mount_image(IMG_GCR, 32'd0);
      lba_a = take_bits(28);
      start_fetch(lba_a, lba_a << 1, 1);
      wait_done(4);
      check_buffer(lba_a << 1, 512);

      // second request during a GCR fetch is dropped
      mount_image(IMG_GCR, 32'h0002_AB00);
      lba_a = take_bits(28);
      lba_b = take_bits(28);
      start_fetch(lba_a, lba_a, 2);
      repeat (12) @(posedge clk_sys);
      pulse_req(lba_b);
      wait_done(20);
      if (sd_req_o.lba !== lba_a) report_mismatch("sd_req_o.lba", lba_a, sd_req_o.lba);
      check_buffer(lba_a, 256);

      $display("errors: %0d, fetches: %0d, bytes checked: %0d", err_cnt, fetch_cnt, byte_cnt);
      if (err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the test sequence finished");
      $display("errors: %0d, fetches: %0d, bytes checked: %0d", err_cnt, fetch_cnt, byte_cnt);
      $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== test/tb_sd_model.sv ====
/*
 * Behavioral SD host
 * answers each read request with ack and a run of buffer byte writes
 */

`timescale 1ns/1ps

module tb_sd_model (
   input  logic               clk_sys,

   input  drive_pkg::sd_req_t sd_req_i,
   output logic               sd_ack_o,
   output logic [9:0]         sd_buff_addr_o,
   output logic               sd_buff_wr_o,

   // lba of the request being served, the data byte is formed from it
   output logic [31:0]        lba_o
);

   import drive_pkg::*;

   // ------------------------------------------------------------------------
   // one read request
   // ------------------------------------------------------------------------

   task automatic serve_read();
      int total;
      int a;
      lba_o = sd_req_i.lba;
      total = int'(sd_req_i.blk_cnt) * BLK_BYTES;
      repeat (3) @(posedge clk_sys);
      #2;
      sd_ack_o = 1'b1;
      // engine leaves its request state once it has seen the ack
      do begin
         @(posedge clk_sys);
         #2;
      end while (sd_req_i.rd === 1'b1);
      for (a = 0; a < total; a++) begin
         sd_buff_addr_o = a[9:0];
         sd_buff_wr_o   = 1'b1;
         @(posedge clk_sys);
         #2;
         sd_buff_wr_o = 1'b0;
         // one or two cycles from byte to byte
         if (a[1]) begin
            @(posedge clk_sys);
            #2;
         end
      end
      sd_ack_o = 1'b0;
   endtask

   initial begin
      sd_ack_o       = 1'b0;
      sd_buff_addr_o = '0;
      sd_buff_wr_o   = 1'b0;
      lba_o          = '0;
      forever begin
         @(posedge clk_sys);
         #2;
         if (sd_req_i.rd === 1'b1) begin
            serve_read();
         end
      end
   end

endmodule

// ==== verilog.f ====
design/drive_pkg.sv
design/sector_fsm.sv
design/xfer_counter.sv
design/sector_buffer.sv
design/drive_engine.sv
design/family_select.sv
design/drive_subsys.sv
test/tb_sd_model.sv
test/tb_drive_subsys.sv
